// File: verilog/core_consts.svh
// Core constants
// Datapath width, register file size and program counter behavior
// for the three-stage RV32I compute core

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////
// Datapath
//////////////////////////////
`define CORE_XLEN        32            // Data and PC width

//////////////////////////////
// Register file
//////////////////////////////
`define CORE_NUM_REGS    32            // x0 to x31
`define CORE_REG_ADDR_W  5             // Register index width

//////////////////////////////
// Program counter
//////////////////////////////
`define CORE_RESET_PC    32'h0000_0000 // PC of first accepted instruction
`define CORE_PC_STEP     32'd4         // One word per instruction

`endif

// File: verilog/rvIsaPkg.sv
// RV32I ISA definitions
// Major opcodes, ALU funct3 codes and the instruction field overlay

`default_nettype none

`include "core_consts.svh"

package rvIsaPkg;

    // Major opcodes, the last five are only named to be rejected
    typedef enum logic [6:0] {
        OP      = 7'b0110011,  // Register-register ALU
        OP_IMM  = 7'b0010011,  // Register-immediate ALU
        LUI     = 7'b0110111,  // Load upper immediate
        AUIPC   = 7'b0010111,  // Add upper immediate to PC
        LOAD    = 7'b0000011,  // Unsupported
        STORE   = 7'b0100011,  // Unsupported
        BRANCH  = 7'b1100011,  // Unsupported
        JAL     = 7'b1101111,  // Unsupported
        JALR    = 7'b1100111   // Unsupported
    } opcodeE;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,      // funct7[5] picks SUB on OP
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,      // funct7[5] picks SRA
        OR      = 3'b110,
        AND     = 3'b111
    } aluFuncE;

    typedef struct packed {
        logic [6:0]                  funct7;
        logic [`CORE_REG_ADDR_W-1:0] rs2;    // Also low imm bits on OP_IMM
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        aluFuncE                     funct3;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        opcodeE                      opcode;
    } instFieldsT;

endpackage

`default_nettype wire

// File: verilog/rvPipePkg.sv
// Pipeline payload types
// Resolved ALU operations and the structs passed between the stages

`default_nettype none

`include "core_consts.svh"

package rvPipePkg;

    // Resolved operation, no further decode in execute
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B                               // LUI result is operand B
    } aluOpE;

    //////////////////////////////
    // Decode to execute
    //////////////////////////////
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_XLEN-1:0]       opA;    // rs1, forwarded value or PC
        logic [`CORE_XLEN-1:0]       opB;    // rs2 or immediate
        aluOpE                       aluOp;
        logic [`CORE_REG_ADDR_W-1:0] rd;
    } execOpT;

    //////////////////////////////
    // Retire stream
    //////////////////////////////
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       value;
    } retireT;

endpackage

`default_nettype wire

// File: verilog/regFile.sv
// Register file
// Two combinational read ports, one registered write port, x0 reads as zero
// and a same-cycle write is bypassed to the readers

`default_nettype none

`include "core_consts.svh"

module regFile (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [`CORE_REG_ADDR_W-1:0] rdAddrA,
    input  wire logic [`CORE_REG_ADDR_W-1:0] rdAddrB,
    input  wire logic [`CORE_REG_ADDR_W-1:0] wrAddr,
    input  wire logic                        wrEn,
    input  wire logic [`CORE_XLEN-1:0]       wrData,
    output      logic [`CORE_XLEN-1:0]       rdDataA,
    output      logic [`CORE_XLEN-1:0]       rdDataB
);

    logic [`CORE_XLEN-1:0] regs [1:`CORE_NUM_REGS-1]; // No storage for x0

    function automatic logic [`CORE_XLEN-1:0] readPort(
        input logic [`CORE_REG_ADDR_W-1:0] addr
    );
        if (addr == '0)                       return '0;     // Hard-wired zero
        else if (wrEn && (wrAddr == addr))    return wrData; // Writeback bypass
        else                                  return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;                          // x0 writes dropped
        end
    end

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    // A write aimed at x0 must leave x0 reading zero afterwards
    aZeroStaysZero: assert property (@(posedge clk) disable iff (rst)
        (wrEn && (wrAddr == '0)) |=> ((rdAddrA != '0) || (rdDataA == '0)));

endmodule

`default_nettype wire

// File: verilog/instDecode.sv
// Decode stage
// Accepts instructions, keeps the PC and the sticky halt flag, builds
// operands with forwarding and loads the execute register

`default_nettype none

`include "core_consts.svh"

module instDecode (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        instValid,
    input  wire logic [31:0]                 instWord,
    input  wire logic                        advance,    // Execute register may load
    input  wire logic [`CORE_XLEN-1:0]       rdDataA,
    input  wire logic [`CORE_XLEN-1:0]       rdDataB,
    input  wire logic [`CORE_REG_ADDR_W-1:0] execRd,
    input  wire logic                        execWrites, // Valid and rd nonzero
    input  wire logic [`CORE_XLEN-1:0]       execResult,
    output      logic                        instReady,
    output      logic                        halt,
    output      logic [`CORE_REG_ADDR_W-1:0] rdAddrA,
    output      logic [`CORE_REG_ADDR_W-1:0] rdAddrB,
    output      logic                        execValid,
    output      rvPipePkg::execOpT           execOp
);

    import rvIsaPkg::*;
    import rvPipePkg::*;

    instFieldsT            fields;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] iImm, uImm;
    logic [`CORE_XLEN-1:0] srcA, srcB;        // Register operands after forwarding
    logic                  supported;
    logic                  accept;
    execOpT                nextOp;

    assign fields    = instFieldsT'(instWord);
    assign iImm      = {{20{fields.funct7[6]}}, fields.funct7, fields.rs2};
    assign uImm      = {instWord[31:12], 12'b0};
    assign rdAddrA   = fields.rs1;
    assign rdAddrB   = fields.rs2;
    assign instReady = advance && !halt;
    assign accept    = instValid && instReady;

    // Execute result wins over the register file, which bypasses writeback
    assign srcA = (execWrites && (execRd == fields.rs1)) ? execResult : rdDataA;
    assign srcB = (execWrites && (execRd == fields.rs2)) ? execResult : rdDataB;

    //////////////////////////////
    // Operation decode
    //////////////////////////////
    always_comb begin
        supported    = 1'b1;
        nextOp.pc    = pc;
        nextOp.rd    = fields.rd;
        nextOp.opA   = srcA;
        nextOp.opB   = iImm;
        nextOp.aluOp = ADD;
        case (fields.opcode)
            OP, OP_IMM: begin
                if (fields.opcode == OP) nextOp.opB = srcB;  // rs2 only on OP
                case (fields.funct3)
                    ADD_SUB:        nextOp.aluOp = (fields.opcode == OP && fields.funct7[5])
                                                 ? SUB : ADD;
                    rvIsaPkg::SLL:  nextOp.aluOp = rvPipePkg::SLL;
                    rvIsaPkg::SLT:  nextOp.aluOp = rvPipePkg::SLT;
                    rvIsaPkg::SLTU: nextOp.aluOp = rvPipePkg::SLTU;
                    rvIsaPkg::XOR:  nextOp.aluOp = rvPipePkg::XOR;
                    SRL_SRA:        nextOp.aluOp = fields.funct7[5] ? SRA : SRL;
                    rvIsaPkg::OR:   nextOp.aluOp = rvPipePkg::OR;
                    default:        nextOp.aluOp = rvPipePkg::AND;
                endcase
            end
            LUI: begin
                nextOp.opA   = '0;                            // Unused by PASS_B
                nextOp.opB   = uImm;
                nextOp.aluOp = PASS_B;
            end
            AUIPC: begin
                nextOp.opA   = pc;
                nextOp.opB   = uImm;
            end
            LOAD, STORE, BRANCH, JAL, JALR: supported = 1'b0; // Dropped from this core
            default:                        supported = 1'b0;
        endcase
    end

    //////////////////////////////
    // PC, halt and execute register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= `CORE_RESET_PC;
            halt      <= 1'b0;
            execValid <= 1'b0;
        end else begin
            if (advance) execValid <= accept && supported;      // Bubble otherwise
            if (accept && !supported) halt <= 1'b1;              // Sticky until reset
            if (accept) pc <= pc + `CORE_PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) execOp <= nextOp;                            // Payload only
    end

    // Once halted the PC freezes and nothing more reaches execute
    aNoAcceptHalted: assert property (@(posedge clk) disable iff (rst)
        halt |=> (halt && $stable(pc) && !execValid));

endmodule

`default_nettype wire

// File: verilog/aluExec.sv
// Execute stage
// ALU for the resolved operation, the writeback register driving the retire
// stream, register file writes and pipeline advance

`default_nettype none

`include "core_consts.svh"

module aluExec (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        execValid,
    input  wire rvPipePkg::execOpT           execOp,
    input  wire logic                        retireReady,
    output      logic                        advance,
    output      logic [`CORE_REG_ADDR_W-1:0] execRd,
    output      logic                        execWrites,
    output      logic [`CORE_XLEN-1:0]       execResult,
    output      logic                        retireValid,
    output      rvPipePkg::retireT           retire,
    output      logic                        wrEn,
    output      logic [`CORE_REG_ADDR_W-1:0] wrAddr,
    output      logic [`CORE_XLEN-1:0]       wrData
);

    import rvPipePkg::*;

    logic [4:0] shamt;
    logic       ltSigned, ltUnsigned;

    assign shamt      = execOp.opB[4:0];                   // RV32 shift amount
    assign ltSigned   = $signed(execOp.opA) < $signed(execOp.opB);
    assign ltUnsigned = execOp.opA < execOp.opB;

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb begin
        case (execOp.aluOp)
            ADD:     execResult = execOp.opA + execOp.opB;
            SUB:     execResult = execOp.opA - execOp.opB;
            SLL:     execResult = execOp.opA << shamt;
            SLT:     execResult = {{(`CORE_XLEN-1){1'b0}}, ltSigned};
            SLTU:    execResult = {{(`CORE_XLEN-1){1'b0}}, ltUnsigned};
            XOR:     execResult = execOp.opA ^ execOp.opB;
            SRL:     execResult = execOp.opA >> shamt;
            SRA:     execResult = $signed(execOp.opA) >>> shamt; // Sign fill
            OR:      execResult = execOp.opA | execOp.opB;
            AND:     execResult = execOp.opA & execOp.opB;
            PASS_B:  execResult = execOp.opB;
            default: execResult = '0;
        endcase
    end

    // Forwarding view of the in-flight instruction
    assign execRd     = execOp.rd;
    assign execWrites = execValid && (execOp.rd != '0);

    //////////////////////////////
    // Writeback register
    //////////////////////////////
    assign advance = !retireValid || retireReady;          // Empty or draining

    always_ff @(posedge clk) begin
        if (rst) begin
            retireValid <= 1'b0;
        end else if (advance) begin
            retireValid <= execValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && execValid) begin
            retire.pc    <= execOp.pc;
            retire.rd    <= execOp.rd;
            retire.value <= execResult;
        end
    end

    // Architectural write happens with the retire transfer
    assign wrEn   = retireValid && retireReady;
    assign wrAddr = retire.rd;
    assign wrData = retire.value;

    // Stalled retire must hold its payload
    aRetireStable: assert property (@(posedge clk) disable iff (rst)
        (retireValid && !retireReady) |=> (retireValid && $stable(retire)));

endmodule

`default_nettype wire

// File: verilog/rvCore.sv
// RV32I compute core top level
// Decode and execute stages around the register file, with instruction
// and retire valid/ready streams

`default_nettype none

`include "core_consts.svh"

module rvCore (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              instValid,
    input  wire logic [31:0]       instWord,
    input  wire logic              retireReady,
    output      logic              instReady,
    output      logic              retireValid,
    output      rvPipePkg::retireT retire,
    output      logic              halt
);

    import rvPipePkg::*;

    logic                        advance;
    logic                        execValid;
    execOpT                      execOp;
    logic [`CORE_REG_ADDR_W-1:0] execRd;
    logic                        execWrites;
    logic [`CORE_XLEN-1:0]       execResult;
    logic [`CORE_REG_ADDR_W-1:0] rdAddrA, rdAddrB, wrAddr;
    logic [`CORE_XLEN-1:0]       rdDataA, rdDataB, wrData;
    logic                        wrEn;

    instDecode uDecode (
        .clk, .rst, .instValid, .instWord, .advance,
        .rdDataA, .rdDataB, .execRd, .execWrites, .execResult,
        .instReady, .halt, .rdAddrA, .rdAddrB, .execValid, .execOp
    );

    aluExec uExec (
        .clk, .rst, .execValid, .execOp, .retireReady,
        .advance, .execRd, .execWrites, .execResult,
        .retireValid, .retire, .wrEn, .wrAddr, .wrData
    );

    regFile uRegs (
        .clk, .rst, .rdAddrA, .rdAddrB, .wrAddr, .wrEn, .wrData,
        .rdDataA, .rdDataB                               // Bypassed reads
    );

endmodule

`default_nettype wire

// File: dv/rvCoreTb.sv
// Testbench for the RV32I compute core
// Directed instruction streams checked against a register and PC reference model

`default_nettype none

`include "core_consts.svh"

module rvCoreTb;

    localparam int         Period   = 40;
    localparam int         TotalIns = 120;                // Upper bound over all tests
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [2:0] F3Add    = 3'd0;
    localparam logic [2:0] F3Sll    = 3'd1;
    localparam logic [2:0] F3Slt    = 3'd2;
    localparam logic [2:0] F3Sltu   = 3'd3;
    localparam logic [2:0] F3Xor    = 3'd4;
    localparam logic [2:0] F3Sr     = 3'd5;
    localparam logic [2:0] F3Or     = 3'd6;
    localparam logic [2:0] F3And    = 3'd7;

    logic              clk = 1'b0;
    logic              rst, instValid, instReady, retireReady, retireValid, halt;
    logic [31:0]       instWord;
    rvPipePkg::retireT retire;

    logic [31:0]       mRegs [0:31];                      // Reference register values
    logic [31:0]       mPc;
    bit                mHalted;
    rvPipePkg::retireT expQ [$];                          // Expected retires in order
    logic [31:0]       progQ [$];
    logic [31:0]       lastPc;
    integer            seed;
    int                errors;
    int                tests;

    rvCore DUT (
        .clk, .rst, .instValid, .instWord, .retireReady,
        .instReady, .retireValid, .retire, .halt
    );

    always #(Period / 2) clk = ~clk;

    initial begin
        #(TotalIns * 40 * Period + 50 * Period);          // 40 cycles per instruction
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////
    // Encoding and reference model
    //////////////////////////////
    function automatic logic [31:0] rInst(input logic [2:0] f3, input bit alt,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OpReg};
    endfunction

    function automatic logic [31:0] iInst(input logic [2:0] f3, input logic [11:0] imm,
                                          input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, OpImm};
    endfunction

    function automatic logic [31:0] uInst(input logic [6:0] opc, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] modelResult(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a  = mRegs[w[19:15]];
        b  = (w[6:0] == OpReg) ? mRegs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh = b[4:0];                                      // RV32 shift amount
        if (w[6:0] == OpLui) return {w[31:12], 12'b0};
        if (w[6:0] == OpAuipc) return mPc + {w[31:12], 12'b0};
        case (w[14:12])
            F3Add:   return (w[6:0] == OpReg && w[30]) ? a - b : a + b;
            F3Sll:   return a << sh;
            F3Slt:   return {31'b0, $signed(a) < $signed(b)};
            F3Sltu:  return {31'b0, a < b};
            F3Xor:   return a ^ b;
            F3Sr: begin
                if (w[30]) return $signed(a) >>> sh;      // Arithmetic shift
                else return a >> sh;
            end
            F3Or:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic modelIssue(input logic [31:0] w);
        rvPipePkg::retireT r;
        if (w[6:0] inside {OpReg, OpImm, OpLui, OpAuipc}) begin
            r.pc    = mPc;
            r.rd    = w[11:7];
            r.value = modelResult(w);
            expQ.push_back(r);
            if (r.rd != 0) mRegs[r.rd] = r.value;         // x0 stays zero
        end else begin
            mHalted = 1'b1;                               // Unsupported, discarded
        end
        mPc = mPc + `CORE_PC_STEP;
    endtask

    //////////////////////////////
    // Stream driver and checker
    //////////////////////////////
    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic runStream(input bit randomReady);
        int                idx;
        bit                held;
        rvPipePkg::retireT heldVal;
        rvPipePkg::retireT exp;
        idx  = 0;
        held = 1'b0;
        instValid <= (progQ.size() > 0);
        if (progQ.size() > 0) instWord <= progQ[0];
        while ((idx < progQ.size() && !mHalted) || expQ.size() > 0) begin
            @(posedge clk);                               // Pre-edge values seen here
            expectEqual("halt", halt, mHalted);
            if (held && (!retireValid || retire !== heldVal)) begin
                $display("Retire payload changed or dropped while stalled");
                errors++;
            end
            if (retireValid && retireReady) begin
                if (expQ.size() == 0) begin
                    $display("Retire transfer with no instruction outstanding");
                    errors++;
                end else begin
                    exp = expQ.pop_front();
                    expectEqual("retire.pc", retire.pc, exp.pc);
                    expectEqual("retire.rd", retire.rd, exp.rd);
                    expectEqual("retire.value", retire.value, exp.value);
                    lastPc = retire.pc;
                end
            end
            held    = retireValid && !retireReady;
            heldVal = retire;
            if (instValid && instReady) begin
                if (mHalted) begin
                    $display("Instruction accepted while halted");
                    errors++;
                end
                modelIssue(progQ[idx]);
                idx++;
            end
            instValid <= (idx < progQ.size());
            if (idx < progQ.size()) instWord <= progQ[idx];
            retireReady <= randomReady ? $random(seed) : 1'b1;
        end
        progQ.delete();
    endtask

    task automatic finishTest(input string name, input int errBefore);
        tests++;
        if (errors == errBefore) $display("%-16s passed", name);
        else $display("%-16s failed with %0d errors", name, errors - errBefore);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic resetState();
        int e0;
        e0 = errors;
        @(posedge clk);
        expectEqual("retireValid", retireValid, 1'b0);
        expectEqual("halt", halt, 1'b0);
        expectEqual("instReady", instReady, 1'b1);
        progQ.push_back(iInst(F3Add, 12'd1, 5'd1, 5'd0));
        runStream(1'b0);
        expectEqual("first retire.pc", lastPc, `CORE_RESET_PC);
        finishTest("reset", e0);
    endtask

    task automatic registerOps();
        int e0;
        e0 = errors;
        progQ.push_back(uInst(OpLui, 20'hF0F0F, 5'd1));
        progQ.push_back(iInst(F3Add, 12'hFF0, 5'd1, 5'd1));    // Negative x1
        progQ.push_back(iInst(F3Add, 12'd5, 5'd2, 5'd0));
        progQ.push_back(iInst(F3Add, 12'hFF9, 5'd3, 5'd0));    // x3 = -7
        progQ.push_back(uInst(OpLui, 20'h12345, 5'd4));
        progQ.push_back(iInst(F3Add, 12'h678, 5'd4, 5'd4));
        progQ.push_back(rInst(F3Add, 1'b0, 5'd10, 5'd1, 5'd2));
        progQ.push_back(rInst(F3Add, 1'b1, 5'd11, 5'd2, 5'd3));  // SUB
        progQ.push_back(rInst(F3Sll, 1'b0, 5'd12, 5'd4, 5'd2));
        progQ.push_back(rInst(F3Slt, 1'b0, 5'd13, 5'd3, 5'd2));
        progQ.push_back(rInst(F3Sltu, 1'b0, 5'd14, 5'd3, 5'd2)); // Mixed signs
        progQ.push_back(rInst(F3Slt, 1'b0, 5'd21, 5'd2, 5'd3));
        progQ.push_back(rInst(F3Sltu, 1'b0, 5'd22, 5'd2, 5'd3));
        progQ.push_back(rInst(F3Xor, 1'b0, 5'd15, 5'd1, 5'd4));
        progQ.push_back(rInst(F3Sr, 1'b0, 5'd16, 5'd1, 5'd2));
        progQ.push_back(rInst(F3Sr, 1'b1, 5'd17, 5'd1, 5'd2));   // SRA negative
        progQ.push_back(rInst(F3Sr, 1'b1, 5'd18, 5'd3, 5'd2));
        progQ.push_back(rInst(F3Or, 1'b0, 5'd19, 5'd1, 5'd2));
        progQ.push_back(rInst(F3And, 1'b0, 5'd20, 5'd1, 5'd4));
        runStream(1'b0);
        finishTest("register ops", e0);
    endtask

    task automatic immediateOps();
        int e0;
        e0 = errors;
        progQ.push_back(iInst(F3Add, 12'hFFF, 5'd23, 5'd4));
        progQ.push_back(iInst(F3Sll, 12'h007, 5'd24, 5'd4));
        progQ.push_back(iInst(F3Slt, 12'hFFD, 5'd25, 5'd3));     // -7 < -3
        progQ.push_back(iInst(F3Slt, 12'hFFD, 5'd26, 5'd2));
        progQ.push_back(iInst(F3Sltu, 12'hFFF, 5'd27, 5'd2));
        progQ.push_back(iInst(F3Xor, 12'h555, 5'd28, 5'd1));
        progQ.push_back(iInst(F3Sr, 12'h004, 5'd29, 5'd1));
        progQ.push_back(iInst(F3Sr, 12'h404, 5'd30, 5'd1));      // SRAI
        progQ.push_back(iInst(F3Or, 12'h0F0, 5'd31, 5'd2));
        progQ.push_back(iInst(F3And, 12'h7FF, 5'd23, 5'd1));
        progQ.push_back(uInst(OpLui, 20'hABCDE, 5'd24));
        progQ.push_back(uInst(OpAuipc, 20'h00010, 5'd25));       // PC plus U immediate
        runStream(1'b0);
        finishTest("immediate ops", e0);
    endtask

    task automatic forwardingChains();
        int e0;
        e0 = errors;
        progQ.push_back(iInst(F3Add, 12'd3, 5'd5, 5'd0));
        progQ.push_back(rInst(F3Add, 1'b0, 5'd6, 5'd5, 5'd5));   // Distance one
        progQ.push_back(rInst(F3Add, 1'b0, 5'd7, 5'd6, 5'd5));   // One and two
        progQ.push_back(rInst(F3Add, 1'b1, 5'd8, 5'd7, 5'd6));
        progQ.push_back(rInst(F3Xor, 1'b0, 5'd9, 5'd8, 5'd7));
        progQ.push_back(iInst(F3Add, 12'd100, 5'd0, 5'd5));      // Write to x0
        progQ.push_back(rInst(F3Add, 1'b0, 5'd10, 5'd0, 5'd5));
        progQ.push_back(rInst(F3Add, 1'b0, 5'd11, 5'd0, 5'd0));
        progQ.push_back(rInst(F3Or, 1'b0, 5'd12, 5'd0, 5'd10));
        runStream(1'b0);
        finishTest("forwarding", e0);
    endtask

    task automatic backPressure();
        int          e0;
        logic [2:0]  f3, rdSel, rs1Sel, rs2Sel;
        logic [11:0] imm;
        bit          alt, useReg;
        e0 = errors;
        repeat (40) begin
            f3     = $random(seed);
            alt    = (f3 == F3Add || f3 == F3Sr) ? $random(seed) : 1'b0;
            useReg = $random(seed);
            rdSel  = $random(seed);                        // x0 to x7, x0 included
            rs1Sel = $random(seed);
            rs2Sel = $random(seed);
            imm    = $random(seed);
            if (f3 == F3Sll || f3 == F3Sr) imm = {1'b0, alt, 5'b0, imm[4:0]};
            if (useReg) progQ.push_back(rInst(f3, alt, {2'b0, rdSel}, {2'b0, rs1Sel},
                                              {2'b0, rs2Sel}));
            else progQ.push_back(iInst(f3, imm, {2'b0, rdSel}, {2'b0, rs1Sel}));
        end
        runStream(1'b1);
        finishTest("back-pressure", e0);
    endtask

    task automatic haltOnStore();
        int e0;
        e0 = errors;
        progQ.push_back(iInst(F3Add, 12'd11, 5'd1, 5'd0));
        progQ.push_back(iInst(F3Add, 12'd1, 5'd2, 5'd1));
        progQ.push_back({7'b0, 5'd1, 5'd0, 3'b010, 5'b0, 7'b0100011}); // SW x1, 0(x0)
        progQ.push_back(iInst(F3Add, 12'd7, 5'd3, 5'd0));
        progQ.push_back(iInst(F3Add, 12'd8, 5'd4, 5'd0));
        runStream(1'b0);
        repeat (8) begin                                   // Later ADDIs stay offered
            @(posedge clk);
            if (instReady || retireValid) begin
                $display("Core accepted or retired an instruction after halt");
                errors++;
            end
            expectEqual("halt", halt, 1'b1);
        end
        instValid <= 1'b0;
        finishTest("halt", e0);
    endtask

    initial begin
        seed        = 32'h7bec_265c;
        errors      = 0;
        tests       = 0;
        rst         = 1'b1;
        instValid   = 1'b0;
        instWord    = '0;
        retireReady = 1'b0;
        lastPc      = '0;
        mPc         = `CORE_RESET_PC;
        mHalted     = 1'b0;
        foreach (mRegs[i]) mRegs[i] = '0;
        repeat (3) @(posedge clk);
        rst         <= 1'b0;
        retireReady <= 1'b1;
        resetState();
        registerOps();
        immediateOps();
        forwardingChains();
        backPressure();
        haltOnStore();                                     // Last, halt is sticky
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/rvIsaPkg.sv
verilog/rvPipePkg.sv
verilog/regFile.sv
verilog/instDecode.sv
verilog/aluExec.sv
verilog/rvCore.sv
dv/rvCoreTb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rvIsaPkg.sv
      - verilog/rvPipePkg.sv
      - verilog/regFile.sv
      - verilog/instDecode.sv
      - verilog/aluExec.sv
      - verilog/rvCore.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/rvCoreTb.sv
